// File: hw/nocPkg.sv
package nocPkg;

  localparam int FlitIdWidth = 3;
  localparam int LenWidth    = 12;
  localparam int NumPorts    = 5;

  // Kind of a flit on a link
  typedef logic [FlitIdWidth-1:0] flitId_t;

  localparam flitId_t FlitIdle   = 3'd0;
  localparam flitId_t FlitHeader = 3'd1;
  localparam flitId_t FlitBody   = 3'd2;
  localparam flitId_t FlitTail   = 3'd3;

  // Hold length carried in the low bits of a header
  typedef logic [LenWidth-1:0] pktLen_t;

  // Bit 0 Local, 1 North, 2 East, 3 West, 4 South
  typedef logic [NumPorts-1:0] portVec_t;

  // One-hot arbiter state, idle in bit 0
  typedef enum logic [NumPorts:0]
  {
    ArbIdle  = 6'b000001,
    ArbLocal = 6'b000010,
    ArbNorth = 6'b000100,
    ArbEast  = 6'b001000,
    ArbWest  = 6'b010000,
    ArbSouth = 6'b100000
  } arbState_e;

endpackage

// File: hw/linkInput.sv
`timescale 1ns/1ps

module linkInput
#(
  parameter int FlitWidth = 32
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inValid,
  input  nocPkg::flitId_t      inFlitId,
  input  logic [FlitWidth-1:0] inData,
  output logic                 valid,
  output nocPkg::flitId_t      regFlitId,
  output logic [FlitWidth-1:0] regData,
  output logic                 req,
  output nocPkg::flitId_t      flitId,
  output nocPkg::pktLen_t      length
);

  import nocPkg::*;

  logic pktOpen;
  logic headerNow;
  logic tailNow;

  assign headerNow = inValid && (inFlitId == FlitHeader);
  assign tailNow   = inValid && (inFlitId == FlitTail);

  // Open from header until the tail has gone by
  always_ff @(posedge clk)
  begin
    if (rst)
      pktOpen <= 1'b0;
    else if (headerNow)
      pktOpen <= 1'b1;
    else if (tailNow)
      pktOpen <= 1'b0;
  end

  assign req = headerNow || pktOpen;

  // Raw kind for the hold timer, idle without strobe
  assign flitId = inValid ? inFlitId : FlitIdle;
  assign length = inData[LenWidth-1:0];

  always_ff @(posedge clk)
  begin
    if (rst)
      valid <= 1'b0;
    else
      valid <= inValid;
  end

  always_ff @(posedge clk)
  begin
    regFlitId <= inFlitId;
    regData   <= inData;
  end

endmodule

// File: hw/flitTimer.sv
`timescale 1ns/1ps

module flitTimer
(
  input  logic            clk,
  input  logic            rst,
  input  nocPkg::flitId_t flitId,
  input  nocPkg::pktLen_t length,
  input  logic            run,
  output logic            timesUp
);

  import nocPkg::*;

  pktLen_t holdLen;
  pktLen_t count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      holdLen <= '0;
      count   <= '0;
    end
    else
    begin
      if (flitId == FlitHeader)
        holdLen <= length;   // Latest header sets the limit
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign timesUp = (count == holdLen);

endmodule

// File: hw/portArbiter.sv
`timescale 1ns/1ps

module portArbiter
(
  input  logic              clk,
  input  logic              rst,
  input  logic              lReq,
  input  nocPkg::flitId_t   lFlitId,
  input  nocPkg::pktLen_t   lLength,
  input  logic              nReq,
  input  nocPkg::flitId_t   nFlitId,
  input  nocPkg::pktLen_t   nLength,
  input  logic              eReq,
  input  nocPkg::flitId_t   eFlitId,
  input  nocPkg::pktLen_t   eLength,
  input  logic              wReq,
  input  nocPkg::flitId_t   wFlitId,
  input  nocPkg::pktLen_t   wLength,
  input  logic              sReq,
  input  nocPkg::flitId_t   sFlitId,
  input  nocPkg::pktLen_t   sLength,
  output nocPkg::portVec_t  grant
);

  import nocPkg::*;

  arbState_e state;
  arbState_e nextState;

  portVec_t reqVec;
  portVec_t runTimer;
  portVec_t timesUp;
  flitId_t  idVec [NumPorts];
  pktLen_t  lenVec [NumPorts];

  logic       holding;
  logic [2:0] holder;

  assign reqVec = {sReq, wReq, eReq, nReq, lReq};

  assign idVec[0]  = lFlitId;
  assign idVec[1]  = nFlitId;
  assign idVec[2]  = eFlitId;
  assign idVec[3]  = wFlitId;
  assign idVec[4]  = sFlitId;
  assign lenVec[0] = lLength;
  assign lenVec[1] = nLength;
  assign lenVec[2] = eLength;
  assign lenVec[3] = wLength;
  assign lenVec[4] = sLength;

  for (genvar i = 0; i < NumPorts; i++)
  begin : genTimer
    flitTimer timer
    (
      .clk     (clk),
      .rst     (rst),
      .flitId  (idVec[i]),
      .length  (lenVec[i]),
      .run     (runTimer[i]),
      .timesUp (timesUp[i])
    );
  end

  // First requester at or after port first, wrapping around
  function automatic arbState_e nextGrant(portVec_t reqs, int unsigned first);
    arbState_e   pick;
    int unsigned idx;
    pick = ArbIdle;
    for (int k = NumPorts - 1; k >= 0; k--)
    begin
      idx = (first + k) % NumPorts;
      if (reqs[idx])
        pick = arbState_e'(6'b000010 << idx);
    end
    return pick;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ArbIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    nextState = ArbIdle;
    runTimer  = '0;
    holding   = 1'b0;
    holder    = 3'd0;
    case (state)
      ArbIdle:
        nextState = nextGrant(reqVec, 0);   // Fixed order from Local
      ArbLocal:
      begin
        holding = 1'b1;
        holder  = 3'd0;
      end
      ArbNorth:
      begin
        holding = 1'b1;
        holder  = 3'd1;
      end
      ArbEast:
      begin
        holding = 1'b1;
        holder  = 3'd2;
      end
      ArbWest:
      begin
        holding = 1'b1;
        holder  = 3'd3;
      end
      ArbSouth:
      begin
        holding = 1'b1;
        holder  = 3'd4;
      end
      default:
        nextState = ArbIdle;
    endcase

    if (holding)
    begin
      if (reqVec[holder] && !timesUp[holder])
      begin
        nextState        = state;
        runTimer[holder] = 1'b1;
      end
      else
      begin
        // Holder drops out, search starts at the next port
        nextState = nextGrant(reqVec & ~(portVec_t'(1) << holder),
                              (holder + 1) % NumPorts);
      end
    end
  end

  assign grant = portVec_t'(state[NumPorts:1]);

endmodule

// File: hw/flitSwitch.sv
`timescale 1ns/1ps

module flitSwitch
#(
  parameter int FlitWidth = 32
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  nocPkg::portVec_t     grant,
  input  logic                 lValid,
  input  nocPkg::flitId_t      lFlitId,
  input  logic [FlitWidth-1:0] lData,
  input  logic                 nValid,
  input  nocPkg::flitId_t      nFlitId,
  input  logic [FlitWidth-1:0] nData,
  input  logic                 eValid,
  input  nocPkg::flitId_t      eFlitId,
  input  logic [FlitWidth-1:0] eData,
  input  logic                 wValid,
  input  nocPkg::flitId_t      wFlitId,
  input  logic [FlitWidth-1:0] wData,
  input  logic                 sValid,
  input  nocPkg::flitId_t      sFlitId,
  input  logic [FlitWidth-1:0] sData,
  output logic                 outValid,
  output nocPkg::flitId_t      outFlitId,
  output logic [FlitWidth-1:0] outData
);

  import nocPkg::*;

  portVec_t                            validVec;
  logic [NumPorts-1:0][FlitIdWidth-1:0] idVec;
  logic [NumPorts-1:0][FlitWidth-1:0]   dataVec;

  logic                 selValid;
  flitId_t              selId;
  logic [FlitWidth-1:0] selData;

  assign validVec = {sValid, wValid, eValid, nValid, lValid};
  assign idVec    = {sFlitId, wFlitId, eFlitId, nFlitId, lFlitId};
  assign dataVec  = {sData, wData, eData, nData, lData};

  // AND-OR select, grant is one-hot or zero
  always_comb
  begin
    selValid = 1'b0;
    selId    = FlitIdle;
    selData  = '0;
    for (int i = 0; i < NumPorts; i++)
    begin
      selValid = selValid | (validVec[i] & grant[i]);
      selId    = selId | (idVec[i] & {FlitIdWidth{grant[i]}});
      selData  = selData | (dataVec[i] & {FlitWidth{grant[i]}});
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selValid;
  end

  always_ff @(posedge clk)
  begin
    if (|grant)
    begin
      outFlitId <= selId;
      outData   <= selData;
    end
  end

endmodule

// File: hw/nocOutputArb.sv
`timescale 1ns/1ps

module nocOutputArb
#(
  parameter int FlitWidth = 32
)
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 lValid,
  input  nocPkg::flitId_t      lFlitId,
  input  logic [FlitWidth-1:0] lData,
  input  logic                 nValid,
  input  nocPkg::flitId_t      nFlitId,
  input  logic [FlitWidth-1:0] nData,
  input  logic                 eValid,
  input  nocPkg::flitId_t      eFlitId,
  input  logic [FlitWidth-1:0] eData,
  input  logic                 wValid,
  input  nocPkg::flitId_t      wFlitId,
  input  logic [FlitWidth-1:0] wData,
  input  logic                 sValid,
  input  nocPkg::flitId_t      sFlitId,
  input  logic [FlitWidth-1:0] sData,
  output nocPkg::portVec_t     grant,
  output logic                 outValid,
  output nocPkg::flitId_t      outFlitId,
  output logic [FlitWidth-1:0] outData
);

  import nocPkg::*;

  // Request side, toward the arbiter
  logic    lReq, nReq, eReq, wReq, sReq;
  flitId_t lKind, nKind, eKind, wKind, sKind;
  pktLen_t lLength, nLength, eLength, wLength, sLength;

  // Registered flits, toward the switch
  logic                 lFwdValid, nFwdValid, eFwdValid, wFwdValid, sFwdValid;
  flitId_t              lFwdId, nFwdId, eFwdId, wFwdId, sFwdId;
  logic [FlitWidth-1:0] lFwdData, nFwdData, eFwdData, wFwdData, sFwdData;

  linkInput #(.FlitWidth(FlitWidth)) lInput
  (
    .clk(clk), .rst(rst), .inValid(lValid), .inFlitId(lFlitId), .inData(lData),
    .valid(lFwdValid), .regFlitId(lFwdId), .regData(lFwdData),
    .req(lReq), .flitId(lKind), .length(lLength)
  );

  linkInput #(.FlitWidth(FlitWidth)) nInput
  (
    .clk(clk), .rst(rst), .inValid(nValid), .inFlitId(nFlitId), .inData(nData),
    .valid(nFwdValid), .regFlitId(nFwdId), .regData(nFwdData),
    .req(nReq), .flitId(nKind), .length(nLength)
  );

  linkInput #(.FlitWidth(FlitWidth)) eInput
  (
    .clk(clk), .rst(rst), .inValid(eValid), .inFlitId(eFlitId), .inData(eData),
    .valid(eFwdValid), .regFlitId(eFwdId), .regData(eFwdData),
    .req(eReq), .flitId(eKind), .length(eLength)
  );

  linkInput #(.FlitWidth(FlitWidth)) wInput
  (
    .clk(clk), .rst(rst), .inValid(wValid), .inFlitId(wFlitId), .inData(wData),
    .valid(wFwdValid), .regFlitId(wFwdId), .regData(wFwdData),
    .req(wReq), .flitId(wKind), .length(wLength)
  );

  linkInput #(.FlitWidth(FlitWidth)) sInput
  (
    .clk(clk), .rst(rst), .inValid(sValid), .inFlitId(sFlitId), .inData(sData),
    .valid(sFwdValid), .regFlitId(sFwdId), .regData(sFwdData),
    .req(sReq), .flitId(sKind), .length(sLength)
  );

  portArbiter arbiter
  (
    .clk(clk), .rst(rst),
    .lReq(lReq), .lFlitId(lKind), .lLength(lLength),
    .nReq(nReq), .nFlitId(nKind), .nLength(nLength),
    .eReq(eReq), .eFlitId(eKind), .eLength(eLength),
    .wReq(wReq), .wFlitId(wKind), .wLength(wLength),
    .sReq(sReq), .sFlitId(sKind), .sLength(sLength),
    .grant(grant)
  );

  flitSwitch #(.FlitWidth(FlitWidth)) switch
  (
    .clk(clk), .rst(rst), .grant(grant),
    .lValid(lFwdValid), .lFlitId(lFwdId), .lData(lFwdData),
    .nValid(nFwdValid), .nFlitId(nFwdId), .nData(nFwdData),
    .eValid(eFwdValid), .eFlitId(eFwdId), .eData(eFwdData),
    .wValid(wFwdValid), .wFlitId(wFwdId), .wData(wFwdData),
    .sValid(sFwdValid), .sFlitId(sFwdId), .sData(sFwdData),
    .outValid(outValid), .outFlitId(outFlitId), .outData(outData)
  );

endmodule

// File: tb/nocOutputArb_chk.sv
`timescale 1ns/1ps

module nocOutputArb_chk
#(
  parameter int FlitWidth = 32
)
(
  input logic                 clk,
  input logic                 rst,
  input logic                 lValid, nValid, eValid, wValid, sValid,
  input nocPkg::flitId_t      lFlitId, nFlitId, eFlitId, wFlitId, sFlitId,
  input logic [FlitWidth-1:0] lData, nData, eData, wData, sData,
  input nocPkg::portVec_t     grant,
  input logic                 outValid,
  input nocPkg::flitId_t      outFlitId,
  input logic [FlitWidth-1:0] outData
);

  import nocPkg::*;

  portVec_t                             validVec, headVec, openVec, reqNow, pastValid;
  logic [NumPorts-1:0][FlitIdWidth-1:0] idVec, pastId;
  logic [NumPorts-1:0][FlitWidth-1:0]   dataVec, pastData;
  pktLen_t                              lastLen [NumPorts];

  portVec_t    prevGrant, expRot, expGrant;
  pktLen_t     heldLen;
  logic [12:0] holdNow, runCnt;   // Consecutive cycles at the current holder
  int          holdIdx;
  logic        loseNow, fromIdle, heldOn, handOff;

  logic                 expValid;
  flitId_t              expId;
  logic [FlitWidth-1:0] expData;

  int failCount = 0;

  assign validVec = {sValid, wValid, eValid, nValid, lValid};
  assign idVec    = {sFlitId, wFlitId, eFlitId, nFlitId, lFlitId};
  assign dataVec  = {sData, wData, eData, nData, lData};
  assign reqNow   = headVec | openVec;

  always_comb
  begin
    headVec = '0;
    for (int i = 0; i < NumPorts; i++)
      headVec[i] = validVec[i] && (idVec[i] == FlitHeader);
  end

  always_comb
  begin
    heldLen = '0;
    holdIdx = 0;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grant[i])
      begin
        heldLen = lastLen[i];
        holdIdx = i;
      end
    end
    holdNow = (grant == '0) ? 13'd0 : (grant == prevGrant) ? runCnt + 13'd1 : 13'd1;
    loseNow = (grant != '0) && (((grant & reqNow) == '0) || (holdNow > {1'b0, heldLen}));
    // Nearest other requester going round from the holder
    expRot = '0;
    for (int k = NumPorts - 1; k > 0; k--)
      if (reqNow[(holdIdx + k) % NumPorts])
        expRot = portVec_t'(1) << ((holdIdx + k) % NumPorts);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      openVec   <= '0;
      prevGrant <= '0;
      runCnt    <= '0;
      pastValid <= '0;
      expValid  <= 1'b0;
      fromIdle  <= 1'b0;
      heldOn    <= 1'b0;
      handOff   <= 1'b0;
      for (int i = 0; i < NumPorts; i++)
        lastLen[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < NumPorts; i++)
      begin
        if (headVec[i])
        begin
          openVec[i] <= 1'b1;
          lastLen[i] <= dataVec[i][LenWidth-1:0];
        end
        else if (validVec[i] && (idVec[i] == FlitTail))
          openVec[i] <= 1'b0;
      end
      prevGrant <= grant;
      runCnt    <= holdNow;
      pastValid <= validVec;
      expValid  <= |(grant & pastValid);
      fromIdle  <= (grant == '0);
      heldOn    <= (grant != '0) && !loseNow;
      handOff   <= loseNow;
    end
  end

  always_ff @(posedge clk)
  begin
    pastId   <= idVec;
    pastData <= dataVec;
    for (int i = 0; i < NumPorts; i++)
    begin
      if (grant[i])
      begin
        expId   <= pastId[i];
        expData <= pastData[i];
      end
    end
    if (grant == '0)
      expGrant <= reqNow & (~reqNow + 1'b1);   // Lowest requesting port
    else if (loseNow)
      expGrant <= expRot;
    else
      expGrant <= grant;
  end

  task automatic flagFail(string msg);
    failCount++;
    $error("%s", msg);
  endtask

  resetZero: assert property (@(posedge clk) $past(rst) |-> grant == '0)
    else flagFail($sformatf("[FAIL] grant %h expected 00 after reset", $sampled(grant)));

  oneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else flagFail($sformatf("[FAIL] grant %h is not one-hot", $sampled(grant)));

  forward: assert property (@(posedge clk) disable iff (rst)
      outValid == expValid && (!expValid || (outFlitId == expId && outData == expData)))
    else flagFail($sformatf("[FAIL] outValid/outFlitId/outData %h/%h/%h expected %h/%h/%h",
      $sampled(outValid), $sampled(outFlitId), $sampled(outData),
      $sampled(expValid), $sampled(expId), $sampled(expData)));

  idleGrant: assert property (@(posedge clk) disable iff (rst) fromIdle |-> grant == expGrant)
    else flagFail($sformatf("[FAIL] grant %h expected %h from idle",
      $sampled(grant), $sampled(expGrant)));

  holdGrant: assert property (@(posedge clk) disable iff (rst) heldOn |-> grant == expGrant)
    else flagFail($sformatf("[FAIL] grant %h expected %h while held",
      $sampled(grant), $sampled(expGrant)));

  rotateGrant: assert property (@(posedge clk) disable iff (rst) handOff |-> grant == expGrant)
    else flagFail($sformatf("[FAIL] grant %h expected %h after release",
      $sampled(grant), $sampled(expGrant)));

endmodule

bind nocOutputArb nocOutputArb_chk #(.FlitWidth(FlitWidth)) chk (.*);

// File: tb/nocOutputArb_tb.sv
`timescale 1ns/1ps

module nocOutputArb_tb;

  import nocPkg::*;

  localparam int FlitWidth  = 32;
  localparam int NumPackets = 120;
  localparam int CycleLimit = 60 * NumPackets + 200;

  logic                 clk = 1'b0;
  logic                 rst = 1'b1;
  logic                 vld [NumPorts];
  flitId_t              fid [NumPorts];
  logic [FlitWidth-1:0] dat [NumPorts];
  portVec_t             grant;
  logic                 outValid;
  flitId_t              outFlitId;
  logic [FlitWidth-1:0] outData;

  logic [31:0] lfsr = 32'hc9f6_1d75;
  int          left [NumPorts];     // Flits still to send including the tail
  logic        rest [NumPorts];     // Forced idle cycle after a tail
  logic        midPkt [NumPorts];
  int          started = 0;
  int          runErrors = 0;
  int          idleGrants = 0;
  int          rotations = 0;
  int          expiries = 0;
  portVec_t    lastGrant = '0;

  always #4 clk = ~clk;

  nocOutputArb #(.FlitWidth(FlitWidth)) nocOutputArb_i
  (
    .clk(clk), .rst(rst),
    .lValid(vld[0]), .lFlitId(fid[0]), .lData(dat[0]),
    .nValid(vld[1]), .nFlitId(fid[1]), .nData(dat[1]),
    .eValid(vld[2]), .eFlitId(fid[2]), .eData(dat[2]),
    .wValid(vld[3]), .wFlitId(fid[3]), .wData(dat[3]),
    .sValid(vld[4]), .sFlitId(fid[4]), .sData(dat[4]),
    .grant(grant), .outValid(outValid), .outFlitId(outFlitId), .outData(outData)
  );

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] drawBits(int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic linksBusy();
    logic busy;
    busy = 1'b0;
    for (int i = 0; i < NumPorts; i++)
      busy = busy || (left[i] > 0);
    return busy;
  endfunction

  task automatic driveLink(int i);
    if (left[i] > 0)
    begin
      vld[i]    = 1'b1;
      fid[i]    = (left[i] == 1) ? FlitTail : FlitBody;
      dat[i]    = drawBits(32);
      midPkt[i] = (left[i] > 1);
      rest[i]   = (left[i] == 1);
      left[i]--;
    end
    else if (!rest[i] && started < NumPackets && drawBits(1) == 1)
    begin
      vld[i]    = 1'b1;
      fid[i]    = FlitHeader;
      dat[i]    = drawBits(32) & 32'hffff_f00f;   // Hold length 0 to 15
      left[i]   = drawBits(5) % 21 + 1;           // Bodies plus the tail
      midPkt[i] = 1'b1;
      started++;
    end
    else
    begin
      vld[i]    = 1'b0;
      fid[i]    = FlitIdle;
      midPkt[i] = 1'b0;
      rest[i]   = 1'b0;
    end
  endtask

  // Grant seen here was decided on the flits driven one cycle ago
  task automatic noteGrant();
    if (lastGrant == '0 && grant != '0)
      idleGrants++;
    if (lastGrant != '0 && grant != lastGrant)
    begin
      if (grant != '0)
        rotations++;
      for (int i = 0; i < NumPorts; i++)
        if (lastGrant[i] && midPkt[i])
          expiries++;
    end
    lastGrant = grant;
  endtask

  task automatic stepCycle();
    @(negedge clk);
    noteGrant();
    for (int i = 0; i < NumPorts; i++)
      driveLink(i);
  endtask

  task automatic requireSeen(int count, string what);
    if (count == 0)
    begin
      runErrors++;
      $display("Stimulus never produced %s", what);
    end
  endtask

  task automatic finishRun();
    $display("Assertion failures: %0d, testbench errors: %0d",
             nocOutputArb_i.chk.failCount, runErrors);
    if (nocOutputArb_i.chk.failCount == 0 && runErrors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  endtask

  initial
  begin
    // Headers under reset must neither open a packet nor win a grant
    for (int i = 0; i < NumPorts; i++)
    begin
      vld[i]    = 1'b1;
      fid[i]    = FlitHeader;
      dat[i]    = 32'h0000_0004;
      left[i]   = 0;
      rest[i]   = 1'b0;
      midPkt[i] = 1'b0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NumPorts; i++)
    begin
      vld[i] = 1'b0;
      fid[i] = FlitIdle;
      dat[i] = '0;
    end
    while (started < NumPackets || linksBusy())
      stepCycle();
    repeat (6)
      stepCycle();   // Drain the last flits
    requireSeen(idleGrants, "a grant from idle");
    requireSeen(rotations, "a hand-off between two ports");
    requireSeen(expiries, "a hold timeout");
    finishRun();
  end

  initial
  begin
    repeat (CycleLimit) @(posedge clk);
    runErrors++;
    $display("Timeout: the run did not finish within %0d cycles", CycleLimit);
    finishRun();
  end

endmodule

// File: nocOutputArb.f
hw/nocPkg.sv
hw/linkInput.sv
hw/flitTimer.sv
hw/portArbiter.sv
hw/flitSwitch.sv
hw/nocOutputArb.sv
tb/nocOutputArb_chk.sv
tb/nocOutputArb_tb.sv

// File: Makefile
# Verilator simulation of the output channel arbiter

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module nocOutputArb_tb -f nocOutputArb.f
	./obj_dir/VnocOutputArb_tb +verilator+error+limit+1000 | tee sim.log
	grep -q "^TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
